/* logic/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Machine word
`define DATA_WIDTH 32

////////////////////
// Primary opcodes
////////////////////
`define OP_SPECIAL 6'h00
`define OP_ADDI    6'h08
`define OP_ADDIU   6'h09
`define OP_ORI     6'h0d
`define OP_LB      6'h20
`define OP_LH      6'h21
`define OP_LW      6'h23
`define OP_LBU     6'h24
`define OP_LHU     6'h25
`define OP_SB      6'h28
`define OP_SH      6'h29
`define OP_SW      6'h2b

// SPECIAL function field
`define FUNCT_ADD  6'h20
`define FUNCT_ADDU 6'h21
`define FUNCT_SUB  6'h22
`define FUNCT_SUBU 6'h23
`define FUNCT_AND  6'h24
`define FUNCT_OR   6'h25
`define FUNCT_SLT  6'h2a

// Cause register exception codes
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5
`define EXC_RI   5'd10
`define EXC_OV   5'd12

`endif

/* logic/excPkg.sv */
`include "cpu_macros.svh"

package excPkg;

	////////////////////
	// Exception record
	////////////////////
	typedef struct packed
	{
		logic excGet;
		logic [4:0] excCode;
		logic [`DATA_WIDTH-1:0] badAddr;
	} excInfoT;

	// Memory access kind and width
	typedef enum logic [1:0] {accNone, accLoad, accStore} accessT;
	typedef enum logic [1:0] {sizeByte, sizeHalf, sizeWord} sizeT;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOpT;

	// Decoded instruction class
	typedef struct packed
	{
		aluOpT aluOp;
		logic canOv;
		logic useImm;
		logic signExt;
		accessT access;
		sizeT size;
	} decodeT;

	////////////////////
	// Stage payloads with valid leading
	////////////////////
	typedef struct packed
	{
		logic valid;
		logic [`DATA_WIDTH-1:0] pc;
		logic [`DATA_WIDTH-1:0] instr;
		logic [`DATA_WIDTH-1:0] operandA;
		logic [`DATA_WIDTH-1:0] operandB;
		decodeT dec;
		excInfoT exc;
	} idStageT;

	// Result is the ALU value or the effective address
	typedef struct packed
	{
		logic valid;
		logic [`DATA_WIDTH-1:0] pc;
		logic [`DATA_WIDTH-1:0] result;
		decodeT dec;
		excInfoT exc;
	} exStageT;

endpackage

/* logic/stageReg.sv */
`timescale 1ns/100ps

module stageReg
#(
	parameter type payloadT = logic
)
(
	input logic clk,
	input logic rstN,
	input logic flush,
	input payloadT d,
	output payloadT q
);

	// Valid is the leading field of every payload
	localparam int validBit = $bits(payloadT) - 1;

	////////////////////
	// Register with flush
	////////////////////
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			q <= '0;
		end
		else if (flush)
		begin
			// Squash the younger instruction
			q <= '0;
		end
		else
		begin
			q <= d;
		end
	end

	// Downstream stages qualify everything with this bit
	validKnown: assert property (@(posedge clk) disable iff (!rstN)
		!$isunknown(q[validBit]))
		else $error("stage valid bit is unknown");

endmodule

/* logic/decodeExcChecker.sv */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module decodeExcChecker
(
	input logic [`DATA_WIDTH-1:0] pc,
	input logic [`DATA_WIDTH-1:0] instr,
	output excPkg::decodeT dec,
	output excPkg::excInfoT exc
);
	import excPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic known;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	////////////////////
	// Instruction class
	////////////////////
	always_comb
	begin
		dec = '0;
		known = 1'b1;
		case (opcode)
			`OP_SPECIAL:
			begin
				case (funct)
					`FUNCT_ADD:
					begin
						dec.aluOp = aluAdd;
						dec.canOv = 1'b1;
					end
					`FUNCT_ADDU: dec.aluOp = aluAdd;
					`FUNCT_SUB:
					begin
						dec.aluOp = aluSub;
						dec.canOv = 1'b1;
					end
					`FUNCT_SUBU: dec.aluOp = aluSub;
					`FUNCT_AND: dec.aluOp = aluAnd;
					`FUNCT_OR: dec.aluOp = aluOr;
					`FUNCT_SLT: dec.aluOp = aluSlt;
					default: known = 1'b0;
				endcase
			end
			`OP_ADDI, `OP_ADDIU:
			begin
				dec.aluOp = aluAdd;
				dec.canOv = (opcode == `OP_ADDI);
				dec.useImm = 1'b1;
				dec.signExt = 1'b1;
			end
			`OP_ORI:
			begin
				// Zero-extended immediate
				dec.aluOp = aluOr;
				dec.useImm = 1'b1;
			end
			`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW, `OP_SB, `OP_SH, `OP_SW:
			begin
				// Base plus signed offset
				dec.aluOp = aluAdd;
				dec.useImm = 1'b1;
				dec.signExt = 1'b1;
				dec.access = opcode[3] ? accStore : accLoad;
				case (opcode[1:0])
					2'b00: dec.size = sizeByte;
					2'b01: dec.size = sizeHalf;
					default: dec.size = sizeWord;
				endcase
			end
			default: known = 1'b0;
		endcase
	end

	// Fetch fault beats reserved instruction
	always_comb
	begin
		exc = '0;
		if (pc[1:0] != 2'b00)
		begin
			exc.excGet = 1'b1;
			exc.excCode = `EXC_ADEL;
			exc.badAddr = pc;
		end
		else if (!known)
		begin
			exc.excGet = 1'b1;
			exc.excCode = `EXC_RI;
		end
	end

endmodule

/* logic/executeAlu.sv */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module executeAlu
(
	input logic [`DATA_WIDTH-1:0] operandA,
	input logic [`DATA_WIDTH-1:0] operandB,
	input logic [`DATA_WIDTH-1:0] instr,
	input excPkg::decodeT dec,
	output logic [`DATA_WIDTH-1:0] result,
	output logic overflow
);
	import excPkg::*;

	localparam int topBit = `DATA_WIDTH - 1;

	logic [`DATA_WIDTH-1:0] imm;
	logic [`DATA_WIDTH-1:0] srcB;
	logic [`DATA_WIDTH-1:0] addB;
	logic [`DATA_WIDTH-1:0] sum;
	logic isSub;

	////////////////////
	// Operand select
	////////////////////
	assign imm = dec.signExt ? {{(`DATA_WIDTH-16){instr[15]}}, instr[15:0]}
		: {{(`DATA_WIDTH-16){1'b0}}, instr[15:0]};
	assign srcB = dec.useImm ? imm : operandB;

	// SLT compares through the subtractor
	assign isSub = (dec.aluOp == aluSub) || (dec.aluOp == aluSlt);

	////////////////////
	// Shared adder that also forms addresses
	////////////////////
	assign addB = isSub ? ~srcB : srcB;
	assign sum = operandA + addB + {{(`DATA_WIDTH-1){1'b0}}, isSub};

	// Same-sign inputs giving a different-sign sum
	assign overflow = (operandA[topBit] == addB[topBit]) && (sum[topBit] != operandA[topBit]);

	always_comb
	begin
		case (dec.aluOp)
			aluAnd: result = operandA & srcB;
			aluOr: result = operandA | srcB;
			aluSlt:
			begin
				// Signed less-than corrected for overflow
				result = {{(`DATA_WIDTH-1){1'b0}}, sum[topBit] ^ overflow};
			end
			aluLui: result = {srcB[15:0], 16'b0};
			default: result = sum;
		endcase
	end

endmodule

/* logic/executeExcChecker.sv */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module executeExcChecker
(
	input excPkg::excInfoT preExc,
	input excPkg::decodeT dec,
	input logic [`DATA_WIDTH-1:0] result,
	input logic overflow,
	output excPkg::excInfoT exc
);
	import excPkg::*;

	logic isLoad;
	logic isStore;

	assign isLoad = (dec.access == accLoad);
	assign isStore = (dec.access == accStore);

	////////////////////
	// Priority merge
	////////////////////
	always_comb
	begin
		exc = '0;
		if (preExc.excGet)
		begin
			// Older fault from decode
			exc = preExc;
		end
		else if (dec.canOv && overflow)
		begin
			exc.excGet = 1'b1;
			exc.excCode = `EXC_OV;
		end
		else if (isStore && overflow)
		begin
			// Address adder wrapped
			exc.excGet = 1'b1;
			exc.excCode = `EXC_ADES;
			exc.badAddr = result;
		end
		else if (isLoad && overflow)
		begin
			exc.excGet = 1'b1;
			exc.excCode = `EXC_ADEL;
			exc.badAddr = result;
		end
	end

endmodule

/* logic/memoryExcChecker.sv */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module memoryExcChecker
(
	input excPkg::excInfoT preExc,
	input excPkg::accessT access,
	input excPkg::sizeT size,
	input logic [`DATA_WIDTH-1:0] addr,
	output excPkg::excInfoT exc
);
	import excPkg::*;

	logic misaligned;

	////////////////////
	// Alignment check
	////////////////////
	always_comb
	begin
		case (size)
			sizeHalf: misaligned = addr[0];
			sizeWord: misaligned = (addr[1:0] != 2'b00);
			// Bytes are always aligned
			default: misaligned = 1'b0;
		endcase
	end

	always_comb
	begin
		exc = preExc;
		if (!preExc.excGet && (access != accNone) && misaligned)
		begin
			exc.excGet = 1'b1;
			exc.excCode = (access == accStore) ? `EXC_ADES : `EXC_ADEL;
			exc.badAddr = addr;
		end
	end

endmodule

/* logic/cp0Exc.sv */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cp0Exc
(
	input logic clk,
	input logic rstN,
	input logic valid,
	input logic [`DATA_WIDTH-1:0] pc,
	input logic [`DATA_WIDTH-1:0] result,
	input excPkg::excInfoT exc,
	output logic flush,
	output logic retireValid,
	output logic [`DATA_WIDTH-1:0] retirePc,
	output logic [`DATA_WIDTH-1:0] retireResult,
	output logic excTaken,
	output logic [`DATA_WIDTH-1:0] epc,
	output logic [`DATA_WIDTH-1:0] badVAddr,
	output logic [4:0] excCode
);

	logic retireNow;
	logic addrFault;

	// Faulting instruction in memory kills both younger ones
	assign flush = valid && exc.excGet;
	assign retireNow = valid && !exc.excGet;

	// Only address errors touch BadVAddr
	assign addrFault = (exc.excCode == `EXC_ADEL) || (exc.excCode == `EXC_ADES);

	////////////////////
	// Control and CP0 registers
	////////////////////
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			retireValid <= 1'b0;
			excTaken <= 1'b0;
			epc <= '0;
			badVAddr <= '0;
			excCode <= '0;
		end
		else
		begin
			retireValid <= retireNow;
			excTaken <= flush;
			if (flush)
			begin
				epc <= pc;
				excCode <= exc.excCode;
				if (addrFault)
					badVAddr <= exc.badAddr;
			end
		end
	end

	// Retire payload
	always_ff @(posedge clk)
	begin
		if (retireNow)
		begin
			retirePc <= pc;
			retireResult <= result;
		end
	end

	// The flushed slot behind an exception stays silent
	flushSquashes: assert property (@(posedge clk) disable iff (!rstN)
		excTaken |=> !(excTaken || retireValid))
		else $error("flushed instruction produced an event after an exception");

endmodule

/* logic/excPipeTop.sv */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module excPipeTop
(
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic [`DATA_WIDTH-1:0] inPc,
	input logic [`DATA_WIDTH-1:0] inInstr,
	input logic [`DATA_WIDTH-1:0] inOperandA,
	input logic [`DATA_WIDTH-1:0] inOperandB,
	output logic retireValid,
	output logic [`DATA_WIDTH-1:0] retirePc,
	output logic [`DATA_WIDTH-1:0] retireResult,
	output logic excTaken,
	output logic [`DATA_WIDTH-1:0] epc,
	output logic [`DATA_WIDTH-1:0] badVAddr,
	output logic [4:0] excCode
);
	import excPkg::*;

	idStageT idD;
	idStageT idQ;
	exStageT exD;
	exStageT exQ;
	decodeT decDec;
	excInfoT decExc;
	excInfoT exExc;
	excInfoT memExc;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic aluOverflow;
	logic flush;

	////////////////////
	// Decode
	////////////////////
	decodeExcChecker uDecode (.pc(inPc), .instr(inInstr), .dec(decDec), .exc(decExc));

	assign idD = '{valid: inValid, pc: inPc, instr: inInstr, operandA: inOperandA,
		operandB: inOperandB, dec: decDec, exc: decExc};

	stageReg #(.payloadT(idStageT)) uIdEx (.clk(clk), .rstN(rstN), .flush(flush),
		.d(idD), .q(idQ));

	////////////////////
	// Execute
	////////////////////
	executeAlu uAlu (.operandA(idQ.operandA), .operandB(idQ.operandB), .instr(idQ.instr),
		.dec(idQ.dec), .result(aluResult), .overflow(aluOverflow));

	executeExcChecker uExExc (.preExc(idQ.exc), .dec(idQ.dec), .result(aluResult),
		.overflow(aluOverflow), .exc(exExc));

	assign exD = '{valid: idQ.valid, pc: idQ.pc, result: aluResult, dec: idQ.dec, exc: exExc};

	stageReg #(.payloadT(exStageT)) uExMem (.clk(clk), .rstN(rstN), .flush(flush),
		.d(exD), .q(exQ));

	////////////////////
	// Memory and CP0
	////////////////////
	memoryExcChecker uMemExc (.preExc(exQ.exc), .access(exQ.dec.access), .size(exQ.dec.size),
		.addr(exQ.result), .exc(memExc));

	cp0Exc uCp0 (.clk(clk), .rstN(rstN), .valid(exQ.valid), .pc(exQ.pc), .result(exQ.result),
		.exc(memExc), .flush(flush), .retireValid(retireValid), .retirePc(retirePc),
		.retireResult(retireResult), .excTaken(excTaken), .epc(epc), .badVAddr(badVAddr),
		.excCode(excCode));

endmodule

/* sim/excPipeTb.sv */
`timescale 1ns/100ps
`include "cpu_macros.svh"

module excPipeTb;

	localparam logic [1:0] kindNone = 2'd0;
	localparam logic [1:0] kindRetire = 2'd1;
	localparam logic [1:0] kindExc = 2'd2;

	typedef struct packed
	{
		logic valid;
		logic [31:0] pc;
		logic [31:0] instr;
		logic [31:0] operandA;
		logic [31:0] operandB;
	} stimT;

	// Expected outcome of one presented slot
	typedef struct packed
	{
		logic [1:0] kind;
		logic [31:0] pc;
		logic [31:0] value;
		logic [4:0] code;
		logic [31:0] bad;
	} expectT;

	logic clk = 1'b0;
	logic rstN;
	logic inValid;
	logic [31:0] inPc;
	logic [31:0] inInstr;
	logic [31:0] inOperandA;
	logic [31:0] inOperandB;
	logic retireValid;
	logic [31:0] retirePc;
	logic [31:0] retireResult;
	logic excTaken;
	logic [31:0] epc;
	logic [31:0] badVAddr;
	logic [4:0] excCode;

	logic [31:0] lcgState;
	expectT pending[$];
	int killLeft = 0;
	int checked = 0;
	int mismatches = 0;
	int otherErrors = 0;
	logic [31:0] modelEpc = '0;
	logic [31:0] modelBad = '0;
	logic [4:0] modelCode = '0;

	excPipeTop DUT (.*);

	always #2 clk = ~clk;

	////////////////////
	// Stimulus
	////////////////////
	function automatic logic [31:0] nextRand();
		logic [15:0] hi;
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		hi = lcgState[31:16];
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return {hi, lcgState[31:16]};
	endfunction

	// Values near the signed limits now and then
	function automatic logic [31:0] pickOperand();
		logic [31:0] r;
		r = nextRand();
		case (r[2:0])
			3'd0: return 32'h7fff_fff0 + {28'd0, r[7:4]};
			3'd1: return 32'h8000_0000 + {28'd0, r[7:4]};
			3'd2: return {28'd0, r[7:4]};
			default: return nextRand();
		endcase
	endfunction

	function automatic stimT makeStim();
		stimT s;
		logic [31:0] r;
		logic [31:0] r2;
		logic [5:0] op;
		logic [5:0] fn;
		r = nextRand();
		r2 = nextRand();
		s.valid = (r[10:8] != 3'd0);
		// Some fetch addresses misaligned
		s.pc = {r[31:4], 4'b0000} | ((r[6:4] == 3'd0) ? {30'd0, r[12:11]} : 32'd0);
		s.operandA = pickOperand();
		s.operandB = pickOperand();
		case (r[3:0])
			4'd6, 4'd7, 4'd8:
			begin
				op = (r[3:0] == 4'd6) ? `OP_ADDI : ((r[3:0] == 4'd7) ? `OP_ADDIU : `OP_ORI);
				s.instr = {op, r2[31:22], r2[15:0]};
			end
			4'd9, 4'd10, 4'd11, 4'd12:
			begin
				case (r2[2:0])
					3'd0: op = `OP_LB;
					3'd1: op = `OP_LBU;
					3'd2: op = `OP_LH;
					3'd3: op = `OP_LHU;
					3'd4: op = `OP_LW;
					3'd5: op = `OP_SB;
					3'd6: op = `OP_SH;
					default: op = `OP_SW;
				endcase
				// Small signed offset
				s.instr = {op, r2[31:22], {12{r2[7]}}, r2[7:4]};
			end
			4'd13: s.instr = r2[0] ? {6'h3f, r2[31:6]} : {`OP_SPECIAL, r2[31:12], 6'h0c};
			default:
			begin
				case (r2[6:4])
					3'd1: fn = `FUNCT_ADDU;
					3'd2: fn = `FUNCT_SUB;
					3'd3: fn = `FUNCT_SUBU;
					3'd4: fn = `FUNCT_AND;
					3'd5: fn = `FUNCT_OR;
					3'd6: fn = `FUNCT_SLT;
					default: fn = `FUNCT_ADD;
				endcase
				s.instr = {`OP_SPECIAL, r2[31:12], fn};
			end
		endcase
		return s;
	endfunction

	////////////////////
	// Reference model
	////////////////////
	function automatic expectT predict(stimT s);
		expectT e;
		logic [5:0] op;
		logic [5:0] fn;
		longint sa;
		longint sb;
		longint si;
		longint wide;
		logic [31:0] value;
		logic [2:0] bytes;
		logic reserved;
		logic ovCheck;
		logic ov;
		logic isStore;
		op = s.instr[31:26];
		fn = s.instr[5:0];
		sa = longint'($signed(s.operandA));
		sb = longint'($signed(s.operandB));
		si = longint'($signed(s.instr[15:0]));
		wide = 0;
		bytes = 3'd0;
		reserved = 1'b0;
		ovCheck = 1'b0;
		case (op)
			`OP_SPECIAL:
			begin
				case (fn)
					`FUNCT_ADD, `FUNCT_ADDU: wide = sa + sb;
					`FUNCT_SUB, `FUNCT_SUBU: wide = sa - sb;
					`FUNCT_AND: wide = {32'd0, s.operandA & s.operandB};
					`FUNCT_OR: wide = {32'd0, s.operandA | s.operandB};
					`FUNCT_SLT: wide = (sa < sb) ? 64'sd1 : 64'sd0;
					default: reserved = 1'b1;
				endcase
				ovCheck = (fn == `FUNCT_ADD) || (fn == `FUNCT_SUB);
			end
			`OP_ADDI, `OP_ADDIU:
			begin
				wide = sa + si;
				ovCheck = (op == `OP_ADDI);
			end
			`OP_ORI: wide = {32'd0, s.operandA | {16'd0, s.instr[15:0]}};
			`OP_LB, `OP_LBU, `OP_SB: bytes = 3'd1;
			`OP_LH, `OP_LHU, `OP_SH: bytes = 3'd2;
			`OP_LW, `OP_SW: bytes = 3'd4;
			default: reserved = 1'b1;
		endcase
		// Effective address for any access
		if (bytes != 3'd0)
			wide = sa + si;
		isStore = (op == `OP_SB) || (op == `OP_SH) || (op == `OP_SW);
		ov = (wide[32] != wide[31]);
		value = wide[31:0];
		e = '0;
		e.pc = s.pc;
		e.value = value;
		e.bad = value;
		if (!s.valid)
			return e;
		e.kind = kindExc;
		// Oldest stage first
		if (s.pc[1:0] != 2'b00)
		begin
			e.code = `EXC_ADEL;
			e.bad = s.pc;
		end
		else if (reserved)
			e.code = `EXC_RI;
		else if (ovCheck && ov)
			e.code = `EXC_OV;
		else if ((bytes != 3'd0 && ov) || (bytes == 3'd2 && value[0])
			|| (bytes == 3'd4 && value[1:0] != 2'b00))
			e.code = isStore ? `EXC_ADES : `EXC_ADEL;
		else
			e.kind = kindRetire;
		return e;
	endfunction

	function automatic int countOutstanding();
		int n;
		n = 0;
		foreach (pending[i])
			if (pending[i].kind != kindNone)
				n++;
		return n;
	endfunction

	////////////////////
	// Checks
	////////////////////
	task automatic checkOutputs();
		expectT e;
		if (pending.size() == 3)
		begin
			e = pending.pop_front();
			checked++;
			case (e.kind)
				kindRetire:
				begin
					assert (retireValid && !excTaken) else
					begin
						otherErrors++;
						$display("Retire of pc %h did not happen at %0t", e.pc, $time);
					end
					assert (!retireValid || (retirePc == e.pc && retireResult == e.value)) else
					begin
						mismatches++;
						$display("mismatch at %0t: retire pc %h result %h, expected pc %h result %h",
							$time, retirePc, retireResult, e.pc, e.value);
					end
				end
				kindExc:
				begin
					assert (excTaken && !retireValid) else
					begin
						otherErrors++;
						$display("Exception of pc %h was not taken at %0t", e.pc, $time);
					end
					modelEpc = e.pc;
					modelCode = e.code;
					// BadVAddr only for address errors
					if (e.code == `EXC_ADEL || e.code == `EXC_ADES)
						modelBad = e.bad;
				end
				default:
				begin
					assert (!retireValid && !excTaken) else
					begin
						mismatches++;
						$display("mismatch at %0t: event for squashed or empty slot pc %h",
							$time, e.pc);
					end
				end
			endcase
		end
		assert (epc == modelEpc && badVAddr == modelBad && excCode == modelCode) else
		begin
			mismatches++;
			$display("mismatch at %0t: epc %h bad %h code %0d, expected %h %h %0d", $time,
				epc, badVAddr, excCode, modelEpc, modelBad, modelCode);
		end
	endtask

	// Check the outputs and then drive the next slot
	task automatic runCycle(stimT s);
		expectT e;
		@(posedge clk);
		#1;
		checkOutputs();
		inValid = s.valid;
		inPc = s.pc;
		inInstr = s.instr;
		inOperandA = s.operandA;
		inOperandB = s.operandB;
		e = predict(s);
		// Two slots behind a fault are flushed
		if (killLeft != 0)
		begin
			e.kind = kindNone;
			killLeft--;
		end
		else if (e.kind == kindExc)
			killLeft = 2;
		pending.push_back(e);
	endtask

	initial
	begin
		int waited;
		lcgState = 32'd18480;
		rstN = 1'b0;
		inValid = 1'b0;
		inPc = '0;
		inInstr = '0;
		inOperandA = '0;
		inOperandB = '0;
		repeat (2) @(posedge clk);
		#1 rstN = 1'b1;
		for (int i = 0; i < 400; i++)
			runCycle(makeStim());
		// Drain with bubbles
		waited = 0;
		while (countOutstanding() != 0 && waited < 8)
		begin
			runCycle('0);
			waited++;
		end
		if (countOutstanding() != 0)
		begin
			otherErrors++;
			$display("Pipeline did not drain within 8 cycles");
		end
		$display("Checked %0d slots: %0d mismatches, %0d other errors", checked, mismatches,
			otherErrors);
		if (mismatches == 0 && otherErrors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* files.f */
+incdir+logic
logic/excPkg.sv
logic/stageReg.sv
logic/decodeExcChecker.sv
logic/executeAlu.sv
logic/executeExcChecker.sv
logic/memoryExcChecker.sv
logic/cp0Exc.sv
logic/excPipeTop.sv
sim/excPipeTb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps -f files.f --top-module excPipeTb -Mdir obj_dir &&
./obj_dir/VexcPipeTb | tee /dev/stderr | grep -qx "Regression passed" &&
echo "Simulation run OK" ||
{ echo "Simulation run not OK"; exit 1; }
